// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= cacheTb
FILELIST ?= icache.f
LOG ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^ALL CHECKS PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: icache.f
rtl/cacheGeomPkg.sv
rtl/cacheCtrlPkg.sv
rtl/cacheLookupIf.sv
rtl/cacheFillIf.sv
rtl/cacheWayStore.sv
rtl/cacheRefill.sv
rtl/cacheCtrl.sv
rtl/cacheTop.sv
tb/axiMemModel.sv
tb/cacheTb.sv

// File: rtl/cacheCtrl.sv
`timescale 1ns/1ps

module cacheCtrl import cacheGeomPkg::*, cacheCtrlPkg::*; (
  input logic clk,
  input logic rst_n,
  input logic [AddrWidth-1:0] addr_i,
  input logic valid_i,
  input logic stall_n_i,
  output logic addr_ok_o,
  output logic data_ok_o,
  output logic data_notok_o,
  output logic [XLen-1:0] rd_data_o,
  cacheLookupIf.ctrl lookup,
  cacheFillIf.ctrl fill
);

  cacheState_e state;
  cacheState_e nextState;
  logic [AddrWidth-1:0] reqLatch;
  logic refillFlag;
  logic hit;
  logic accept;
  logic [BeatCntWidth-1:0] wordSel;
  logic [LineWidth-1:0] srcLine;

  // fresh refill counts as a hit for one Compare cycle
  assign hit = (|lookup.wayHit) || refillFlag;

  // stall_n low blocks any accept
  assign addr_ok_o = stall_n_i && (state == Idle || (state == Compare && hit));
  assign accept = valid_i && addr_ok_o;

  assign data_ok_o = (state == Compare) && hit;
  assign data_notok_o = (state == Compare && !hit) || state == Miss || state == GetData;

  always_comb begin
    nextState = state;
    case (state)
      Idle: begin
        if (accept) begin
          nextState = Compare;
        end
      end
      Compare: begin
        if (!hit) begin
          nextState = Miss;
        end else if (!accept) begin
          nextState = Idle;
        end
      end
      // wait here until the burst request is taken
      Miss: begin
        if (fill.reqSent) begin
          nextState = GetData;
        end
      end
      GetData: begin
        if (fill.beatDone) begin
          nextState = Compare;
        end
      end
      default: nextState = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
      refillFlag <= 1'b0;
    end else begin
      state <= nextState;
      refillFlag <= lookup.fillEn;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqLatch <= addr_i;
    end
  end

  // array read overlaps compare of the previous request
  assign lookup.rdEn = accept;
  assign lookup.rdIndex = addr_i[OffsetWidth +: IndexWidth];
  assign lookup.cmpTag = reqLatch[AddrWidth-1 -: TagWidth];

  // install on the last beat edge
  assign lookup.fillEn = (state == GetData) && fill.beatDone;
  assign lookup.fillIndex = reqLatch[OffsetWidth +: IndexWidth];
  assign lookup.fillLine = fill.line;

  assign fill.start = (state == Miss);
  assign fill.lineAddr = {reqLatch[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};

  // word pick, offset bits 4:3
  assign wordSel = reqLatch[OffsetWidth-1 -: BeatCntWidth];

  always_comb begin
    if (refillFlag) begin
      srcLine = fill.line;
    end else if (lookup.wayHit[1]) begin
      srcLine = lookup.wayData[1];
    end else begin
      srcLine = lookup.wayData[0];
    end
  end

  assign rd_data_o = srcLine[wordSel*XLen +: XLen];

endmodule

// File: rtl/cacheCtrlPkg.sv
package cacheCtrlPkg;

  // request FSM
  typedef enum logic [1:0] {
    Idle,
    Compare,
    Miss,
    GetData
  } cacheState_e;

  // replacement lfsr start value, must be nonzero
  localparam logic [15:0] LfsrSeed = 16'hB5A3;

endpackage

// File: rtl/cacheFillIf.sv
`timescale 1ns/1ps

interface cacheFillIf import cacheGeomPkg::*; ();

  // level, high for the whole Miss state
  logic start;
  logic [AddrWidth-1:0] lineAddr;

  // burst request went out this cycle
  logic reqSent;
  // last beat taken this cycle
  logic beatDone;
  logic [LineWidth-1:0] line;

  modport ctrl (output start, lineAddr, input reqSent, beatDone, line);

  modport refill (input start, lineAddr, output reqSent, beatDone, line);

endinterface

// File: rtl/cacheGeomPkg.sv
package cacheGeomPkg;

  // byte address and data word
  localparam int AddrWidth = 32;
  localparam int XLen = 64;

  // line layout, four words per line
  localparam int BeatsPerLine = 4;
  localparam int BeatCntWidth = $clog2(BeatsPerLine);
  localparam int LineWidth = XLen * BeatsPerLine;
  localparam int OffsetWidth = $clog2(LineWidth / 8);

  // array shape
  localparam int IndexWidth = 6;
  localparam int Sets = 1 << IndexWidth;
  localparam int Ways = 2;

  // whatever is left above index and offset
  localparam int TagWidth = AddrWidth - IndexWidth - OffsetWidth;

endpackage

// File: rtl/cacheLookupIf.sv
`timescale 1ns/1ps

interface cacheLookupIf import cacheGeomPkg::*; ();

  // read side, index taken straight from the pipeline address
  logic [IndexWidth-1:0] rdIndex;
  logic rdEn;
  logic [TagWidth-1:0] cmpTag;

  // line install after refill
  logic fillEn;
  logic [IndexWidth-1:0] fillIndex;
  logic [LineWidth-1:0] fillLine;

  // per-way results of the last read
  logic [Ways-1:0] wayHit;
  logic [Ways-1:0][LineWidth-1:0] wayData;

  modport ctrl (
    output rdIndex, rdEn, cmpTag, fillEn, fillIndex, fillLine,
    input wayHit, wayData
  );

  modport store (
    input rdIndex, rdEn, cmpTag, fillEn, fillIndex, fillLine,
    output wayHit, wayData
  );

endinterface

// File: rtl/cacheRefill.sv
`timescale 1ns/1ps

module cacheRefill import cacheGeomPkg::*; (
  input logic clk,
  input logic rst_n,
  input logic axiRdReady_i,
  input logic [XLen-1:0] rdData_i,
  input logic dataValid_i,
  input logic rdLast_i,
  output logic cacheRdValid_o,
  output logic [AddrWidth-1:0] cacheAddr_o,
  cacheFillIf.refill fill
);

  logic busy;
  logic beatTake;
  logic [BeatCntWidth-1:0] beatCnt;
  logic [LineWidth-1:0] lineBuf;
  logic [LineWidth-1:0] lineNext;

  // one-cycle request, memory ready seen during Miss
  assign cacheRdValid_o = fill.start && axiRdReady_i;
  assign cacheAddr_o = fill.lineAddr;
  assign fill.reqSent = cacheRdValid_o;

  // beats only count once the burst is out
  assign beatTake = busy && dataValid_i;
  assign fill.beatDone = beatTake && rdLast_i;

  // buffer with the incoming beat merged in
  // so the install edge already sees the full line
  always_comb begin
    lineNext = lineBuf;
    if (beatTake) begin
      lineNext[beatCnt*XLen +: XLen] = rdData_i;
    end
  end

  assign fill.line = lineNext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      beatCnt <= '0;
    end else begin
      if (cacheRdValid_o) begin
        busy <= 1'b1;
      end else if (fill.beatDone) begin
        busy <= 1'b0;
      end
      // counter parked at zero while waiting for ready
      if (fill.start) begin
        beatCnt <= '0;
      end else if (beatTake) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    lineBuf <= lineNext;
  end

endmodule

// File: rtl/cacheTop.sv
`timescale 1ns/1ps

module cacheTop import cacheGeomPkg::*; (
  input logic clk,
  input logic rst_n,
  // pipeline side
  input logic [AddrWidth-1:0] addr_i,
  input logic valid_i,
  input logic stall_n_i,
  output logic addr_ok_o,
  output logic data_ok_o,
  output logic data_notok_o,
  output logic [XLen-1:0] rd_data_o,
  // memory side
  output logic cacheRdValid_o,
  input logic axiRdReady_i,
  output logic [AddrWidth-1:0] cacheAddr_o,
  input logic [XLen-1:0] rdData_i,
  input logic dataValid_i,
  input logic rdLast_i
);

  cacheLookupIf lookupBus ();
  cacheFillIf fillBus ();

  cacheCtrl uCtrl (
    .clk (clk),
    .rst_n (rst_n),
    .addr_i (addr_i),
    .valid_i (valid_i),
    .stall_n_i (stall_n_i),
    .addr_ok_o (addr_ok_o),
    .data_ok_o (data_ok_o),
    .data_notok_o (data_notok_o),
    .rd_data_o (rd_data_o),
    .lookup (lookupBus.ctrl),
    .fill (fillBus.ctrl)
  );

  cacheWayStore uStore (
    .clk (clk),
    .rst_n (rst_n),
    .lookup (lookupBus.store)
  );

  cacheRefill uRefill (
    .clk (clk),
    .rst_n (rst_n),
    .axiRdReady_i (axiRdReady_i),
    .rdData_i (rdData_i),
    .dataValid_i (dataValid_i),
    .rdLast_i (rdLast_i),
    .cacheRdValid_o (cacheRdValid_o),
    .cacheAddr_o (cacheAddr_o),
    .fill (fillBus.refill)
  );

endmodule

// File: rtl/cacheWayStore.sv
`timescale 1ns/1ps

module cacheWayStore import cacheGeomPkg::*, cacheCtrlPkg::*; (
  input logic clk,
  input logic rst_n,
  cacheLookupIf.store lookup
);

  localparam int HalfWidth = LineWidth / 2;

  logic [Ways-1:0][Sets-1:0] validBits;
  logic [Ways-1:0] validQ;
  logic [15:0] lfsr;
  logic lfsrFb;
  logic victim;

  // taps 16,14,13,11
  assign lfsrFb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

  // empty way first, random pick only when the set is full
  always_comb begin
    if (!validBits[0][lookup.fillIndex]) begin
      victim = 1'b0;
    end else if (!validBits[1][lookup.fillIndex]) begin
      victim = 1'b1;
    end else begin
      victim = lfsr[0];
    end
  end

  // valid bits, plus their copy latched with each read
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validBits <= '0;
      validQ <= '0;
    end else begin
      if (lookup.fillEn) begin
        validBits[victim][lookup.fillIndex] <= 1'b1;
      end
      if (lookup.rdEn) begin
        for (int w = 0; w < Ways; w++) begin
          validQ[w] <= validBits[w][lookup.rdIndex];
        end
      end
    end
  end

  // steps once per install
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsr <= LfsrSeed;
    end else if (lookup.fillEn) begin
      lfsr <= {lfsr[14:0], lfsrFb};
    end
  end

  for (genvar w = 0; w < Ways; w++) begin : gWay
    logic [TagWidth-1:0] tagArr [Sets];
    // line kept as two half-width arrays per way
    logic [HalfWidth-1:0] dataLo [Sets];
    logic [HalfWidth-1:0] dataHi [Sets];
    logic [TagWidth-1:0] tagQ;
    logic [LineWidth-1:0] dataQ;
    logic wayWe;

    assign wayWe = lookup.fillEn && (victim == 1'(w));

    // sync read, output holds until the next rdEn
    always_ff @(posedge clk) begin
      if (wayWe) begin
        tagArr[lookup.fillIndex] <= lookup.cmpTag;
        dataLo[lookup.fillIndex] <= lookup.fillLine[HalfWidth-1:0];
        dataHi[lookup.fillIndex] <= lookup.fillLine[LineWidth-1:HalfWidth];
      end
      if (lookup.rdEn) begin
        tagQ <= tagArr[lookup.rdIndex];
        dataQ <= {dataHi[lookup.rdIndex], dataLo[lookup.rdIndex]};
      end
    end

    assign lookup.wayHit[w] = validQ[w] && (tagQ == lookup.cmpTag);
    assign lookup.wayData[w] = dataQ;
  end

endmodule

// File: tb/axiMemModel.sv
`timescale 1ns/1ps

module axiMemModel import cacheGeomPkg::*; (
  input logic clk,
  input logic rst_n,
  input logic cacheRdValid_i,
  input logic [AddrWidth-1:0] cacheAddr_i,
  output logic axiRdReady_o,
  output logic [XLen-1:0] rdData_o,
  output logic dataValid_o,
  output logic rdLast_o
);

  logic readyQ = 1'b0;
  logic validQ = 1'b0;
  logic lastQ = 1'b0;
  logic bursting = 1'b0;
  logic [XLen-1:0] dataQ = '0;
  logic [AddrWidth-1:0] beatAddr = '0;
  logic [BeatCntWidth-1:0] beatCnt = '0;
  int delay = 0;

  assign axiRdReady_o = readyQ;
  assign rdData_o = dataQ;
  assign dataValid_o = validQ;
  assign rdLast_o = lastQ;

  // upper half is the word address, lower half its inverse
  function automatic logic [XLen-1:0] wordAt(input logic [AddrWidth-1:0] a);
    return {a, ~a};
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      readyQ <= 1'b0;
      validQ <= 1'b0;
      lastQ <= 1'b0;
      bursting <= 1'b0;
      beatCnt <= '0;
      delay <= 0;
    end else if (bursting) begin
      // one beat per cycle in address order
      validQ <= 1'b1;
      dataQ <= wordAt(beatAddr);
      lastQ <= (beatCnt == BeatCntWidth'(BeatsPerLine - 1));
      beatAddr <= beatAddr + XLen / 8;
      beatCnt <= beatCnt + 1'b1;
      if (beatCnt == BeatCntWidth'(BeatsPerLine - 1)) begin
        bursting <= 1'b0;
        // ready comes back after 0 to 5 idle cycles
        delay <= $urandom_range(5, 0);
      end
    end else begin
      validQ <= 1'b0;
      lastQ <= 1'b0;
      if (cacheRdValid_i) begin
        readyQ <= 1'b0;
        bursting <= 1'b1;
        beatAddr <= cacheAddr_i;
        beatCnt <= '0;
      end else if (delay > 0) begin
        delay <= delay - 1;
      end else begin
        readyQ <= 1'b1;
      end
    end
  end

endmodule

// File: tb/cacheTb.sv
`timescale 1ns/1ps

module cacheTb import cacheGeomPkg::*; ();

  localparam int WaitLimit = 200;

  logic clk = 1'b0;
  logic rst_n;
  logic [AddrWidth-1:0] addr_i;
  logic valid_i;
  logic stall_n_i;
  logic addr_ok_o;
  logic data_ok_o;
  logic data_notok_o;
  logic [XLen-1:0] rd_data_o;
  logic cacheRdValid_o;
  logic axiRdReady_i;
  logic [AddrWidth-1:0] cacheAddr_o;
  logic [XLen-1:0] rdData_i;
  logic dataValid_i;
  logic rdLast_i;

  int errCount = 0;
  int testCount = 0;
  int testsFailed = 0;
  int testErrBase = 0;
  int reqCount = 0;
  logic [AddrWidth-1:0] lastReqAddr = '0;
  logic [AddrWidth-1:0] acceptAddr = '0;
  bit timedOut = 1'b0;

  // 4 ns period
  always #2 clk = ~clk;

  cacheTop UUT (
    .clk (clk),
    .rst_n (rst_n),
    .addr_i (addr_i),
    .valid_i (valid_i),
    .stall_n_i (stall_n_i),
    .addr_ok_o (addr_ok_o),
    .data_ok_o (data_ok_o),
    .data_notok_o (data_notok_o),
    .rd_data_o (rd_data_o),
    .cacheRdValid_o (cacheRdValid_o),
    .axiRdReady_i (axiRdReady_i),
    .cacheAddr_o (cacheAddr_o),
    .rdData_i (rdData_i),
    .dataValid_i (dataValid_i),
    .rdLast_i (rdLast_i)
  );

  axiMemModel uMem (
    .clk (clk),
    .rst_n (rst_n),
    .cacheRdValid_i (cacheRdValid_o),
    .cacheAddr_i (cacheAddr_o),
    .axiRdReady_o (axiRdReady_i),
    .rdData_o (rdData_i),
    .dataValid_o (dataValid_i),
    .rdLast_o (rdLast_i)
  );

  // address in the upper half and its inverse below
  function automatic logic [XLen-1:0] memWord(input logic [AddrWidth-1:0] a);
    logic [AddrWidth-1:0] al;
    al = {a[AddrWidth-1:3], 3'b000};
    return {al, ~al};
  endfunction

  function automatic void reportFail(input string msg);
    errCount++;
    $display("[FAIL] %0t: %s", $time, msg);
  endfunction

  function automatic void reportTimeout(input string what);
    errCount++;
    timedOut = 1'b1;
    $display("timeout: the wait for %s ran out after %0d cycles", what, WaitLimit);
  endfunction

  // burst requests and accepted addresses taken mid-cycle
  always @(negedge clk) begin
    if (rst_n && cacheRdValid_o) begin
      reqCount <= reqCount + 1;
      lastReqAddr <= cacheAddr_o;
    end
    if (rst_n && valid_i && addr_ok_o) begin
      acceptAddr <= addr_i;
    end
  end

  // protocol rules checked every cycle
  strobesExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(data_ok_o && data_notok_o))
    else reportFail("data_ok_o and data_notok_o high together");

  stallBlocksAccept: assert property (@(posedge clk) disable iff (!rst_n)
    !stall_n_i |-> !addr_ok_o)
    else reportFail("addr_ok_o high while stalled");

  // 32-byte line of the request that missed
  burstAddrMatches: assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_o |-> (cacheAddr_o == (acceptAddr & ~32'h1F)))
    else reportFail("burst address is not the line of the missed request");

  burstSinglePulse: assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_o |=> !cacheRdValid_o)
    else reportFail("cacheRdValid_o longer than one cycle");

  burstOnlyOnMiss: assert property (@(posedge clk) disable iff (!rst_n)
    cacheRdValid_o |-> data_notok_o)
    else reportFail("burst request outside a miss");

  // after an accept data_notok_o holds until data_ok_o
  notokUntilData: assert property (@(posedge clk) disable iff (!rst_n)
    ((valid_i && addr_ok_o) || data_notok_o) |=> (data_ok_o || data_notok_o))
    else reportFail("no data_ok_o or data_notok_o while a request is open");

  task automatic startTest();
    testErrBase = errCount;
    testCount++;
  endtask

  task automatic finishTest(input string name);
    if (errCount == testErrBase) begin
      $display("test %-8s ok", name);
    end else begin
      testsFailed++;
      $display("test %-8s %0d errors", name, errCount - testErrBase);
    end
  endtask

  // request already driven so drop valid after the accept edge
  task automatic waitAccept();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!addr_ok_o && cnt < WaitLimit) begin
      @(negedge clk);
      cnt++;
    end
    if (!addr_ok_o) begin
      reportTimeout("addr_ok_o");
    end
    @(posedge clk);
    valid_i <= 1'b0;
  endtask

  task automatic waitData(input logic [AddrWidth-1:0] addr, output int lat);
    lat = 0;
    if (timedOut) return;
    do begin
      @(negedge clk);
      lat++;
    end while (!data_ok_o && lat < WaitLimit);
    if (!data_ok_o) begin
      reportTimeout("data_ok_o");
    end else begin
      assert (rd_data_o == memWord(addr))
        else reportFail($sformatf("read %08h gave %016h, expected %016h",
                                  addr, rd_data_o, memWord(addr)));
    end
  endtask

  task automatic readWord(input logic [AddrWidth-1:0] addr, output int lat, output int reqs);
    int reqBase;
    reqBase = reqCount;
    lat = 0;
    reqs = 0;
    if (timedOut) return;
    @(posedge clk);
    valid_i <= 1'b1;
    addr_i <= addr;
    waitAccept();
    waitData(addr, lat);
    reqs = reqCount - reqBase;
  endtask

  task automatic checkMiss(input logic [AddrWidth-1:0] addr);
    int lat;
    int reqs;
    readWord(addr, lat, reqs);
    if (timedOut) return;
    assert (reqs == 1 && lastReqAddr == (addr & ~32'h1F))
      else reportFail($sformatf("miss %08h: %0d bursts, last at %08h", addr, reqs, lastReqAddr));
    assert (lat > 1) else reportFail($sformatf("miss %08h answered in one cycle", addr));
  endtask

  task automatic checkHit(input logic [AddrWidth-1:0] addr);
    int lat;
    int reqs;
    readWord(addr, lat, reqs);
    if (timedOut) return;
    assert (reqs == 0 && lat == 1)
      else reportFail($sformatf("hit %08h: latency %0d, %0d bursts", addr, lat, reqs));
  endtask

  // back-to-back hits with valid held high across the whole run
  task automatic readBurst(input logic [AddrWidth-1:0] base, input int n);
    int reqBase;
    int cnt;
    logic [AddrWidth-1:0] a;
    reqBase = reqCount;
    cnt = 0;
    if (timedOut) return;
    @(posedge clk);
    valid_i <= 1'b1;
    addr_i <= base;
    @(negedge clk);
    while (!addr_ok_o && cnt < WaitLimit) begin
      @(negedge clk);
      cnt++;
    end
    if (!addr_ok_o) begin
      reportTimeout("addr_ok_o");
    end
    for (int i = 0; i < n; i++) begin
      a = base + 32'(8 * i);
      @(posedge clk);
      if (i + 1 < n) begin
        addr_i <= a + 8;
      end else begin
        valid_i <= 1'b0;
      end
      @(negedge clk);
      assert (data_ok_o && rd_data_o == memWord(a))
        else reportFail($sformatf("burst hit %08h missing or wrong", a));
      if (i + 1 < n) begin
        assert (addr_ok_o) else reportFail("next hit not accepted");
      end
    end
    assert (reqCount == reqBase) else reportFail("hit burst caused a refill");
  endtask

  initial begin
    int lat;
    int reqs;
    int reqBase;
    logic [AddrWidth-1:0] a;
    void'($urandom(9256));
    rst_n = 1'b0;
    valid_i = 1'b0;
    addr_i = '0;
    stall_n_i = 1'b1;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    startTest();
    @(negedge clk);
    assert (!data_ok_o && !data_notok_o && !cacheRdValid_o && addr_ok_o)
      else reportFail("outputs not idle after reset");
    checkMiss(32'h0000_1008);
    finishTest("reset");

    startTest();
    checkMiss(32'h0002_2418);
    checkMiss(32'h0004_57F0);
    finishTest("miss");

    // every word of a resident line one by one then back to back
    startTest();
    for (int w = 0; w < 4; w++) begin
      checkHit(32'h0002_2400 + 32'(8 * w));
    end
    readBurst(32'h0002_2400, 4);
    finishTest("hit");

    // three tags in set 9
    startTest();
    checkMiss(32'h0010_0120);
    checkMiss(32'h0020_0128);
    checkHit(32'h0010_0130);
    checkHit(32'h0020_0138);
    checkMiss(32'h0030_0120);
    checkHit(32'h0030_0128);
    readWord(32'h0010_0120, lat, reqs);
    // first tag kept so the second one went
    if (!timedOut && reqs == 0) begin
      checkMiss(32'h0020_0120);
    end
    finishTest("ways");

    startTest();
    reqBase = reqCount;
    @(posedge clk);
    stall_n_i <= 1'b0;
    valid_i <= 1'b1;
    addr_i <= 32'h0003_0C20;
    repeat (6) begin
      @(negedge clk);
      assert (!addr_ok_o && !data_ok_o) else reportFail("request taken while stalled");
    end
    assert (reqCount == reqBase) else reportFail("burst issued while stalled");
    @(posedge clk);
    stall_n_i <= 1'b1;
    waitAccept();
    waitData(32'h0003_0C20, lat);
    finishTest("stall");

    // four tags over sets 20 to 23
    startTest();
    for (int i = 0; i < 40; i++) begin
      a = ((($urandom % 4) + 1) << 11) | ((20 + ($urandom % 4)) << 5) | (($urandom % 4) << 3);
      readWord(a, lat, reqs);
      assert (timedOut || (reqs == 0 && lat == 1) || (reqs == 1 && lat > 1))
        else reportFail($sformatf("read %08h: latency %0d, %0d bursts", a, lat, reqs));
    end
    finishTest("random");

    $display("%0d tests, %0d failed, %0d errors", testCount, testsFailed, errCount);
    if (errCount == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
